// File: dv/tb_video_to_ram.sv
// Self-checking testbench for video_to_ram; run through sim.f with the top module tb_video_to_ram
`timescale 1ns/1ps

module tb_video_to_ram;

	localparam int          NUM_LINES      = 6;
	localparam int          PIXELS         = 64;
	localparam int          LINE_PIX       = vram_pkg::READ_OFFSET + PIXELS;
	localparam logic [31:0] BASE           = 32'h1000_0000;
	// Lines times (pixels plus bursts of worst case stalled beats), plus margin
	localparam int          TIMEOUT_CYCLES = NUM_LINES * (LINE_PIX + 16 * (4 * (4 + 1))) + 200;

	logic                          i_clk_100_bus = 1'b0;
	logic                          i_sys_rst;
	logic                          i_pix_valid;
	logic [23:0]                   i_pix_rgb;
	logic [7:0]                    i_pix_luma;
	logic                          i_line_end;
	logic [9:0]                    i_line_num;
	logic                          i_mem_init_done;
	logic                          i_sl_addr_ack;
	logic                          i_pa_valid;
	logic                          i_m_wr_dack;
	logic                          i_sl_wr_comp;
	logic                          o_m_request;
	logic                          o_m_wr_burst;
	logic [31:0]                   o_m_abus;
	logic [31:0]                   o_m_wr_data;
	logic [7:0]                    o_luma_data;
	logic                          o_luma_valid;
	logic                          o_new_line;
	logic [9:0]                    o_line_cnt;
	vram_pkg::writer_state_t       o_writer_state;

	// Reference model of every line sent
	logic [23:0]                   model_rgb  [NUM_LINES][LINE_PIX];
	logic [7:0]                    model_luma [NUM_LINES][LINE_PIX];
	logic [9:0]                    line_nums  [NUM_LINES];
	logic [31:0]                   rng_state;
	logic [31:0]                   exp_word;
	logic                          prev_new_line = 1'b0;
	int                            line_idx = 0;
	int                            req_cnt = 0;
	int                            beat_cnt = 0;
	int                            cycle_cnt = 0;

	video_to_ram #(.P_PIXELS_PER_LINE(PIXELS), .P_VIDEO_RAM_BASE(BASE)) dut0 (.*);

	always #5 i_clk_100_bus = ~i_clk_100_bus;

	//////////////////////////////
	// Helpers
	//////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Inputs change 1 ns after the rising edge
	task automatic tick();
		@(posedge i_clk_100_bus);
		#1;
	endtask

	task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		$display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
		$display("TEST RESULT: FAIL");
		$fatal(1, "value mismatch on %s", name);
	endtask

	task automatic report_error(input string msg);
		$display("Error at %0t: %s", $time, msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "%s", msg);
	endtask

	// Fill one buffer, then end the line once the writer has released the other
	task automatic send_line(input int ln);
		rng_state = xorshift32(rng_state);
		line_nums[ln] = {rng_state[6:0], 3'(ln)};
		for (int p = 0; p < LINE_PIX; p++)
		begin
			rng_state = xorshift32(rng_state);
			model_rgb[ln][p]  = rng_state[23:0];
			model_luma[ln][p] = rng_state[31:24];
			i_pix_valid = 1'b1;
			i_pix_rgb   = rng_state[23:0];
			i_pix_luma  = rng_state[31:24];
			tick();
		end
		i_pix_valid = 1'b0;
		while (o_new_line)
			tick();
		i_line_end = 1'b1;
		i_line_num = line_nums[ln];
		tick();
		i_line_end = 1'b0;
	endtask

	//////////////////////////////
	// Slave model
	//////////////////////////////

	initial
	begin
		wait (i_sys_rst === 1'b0);
		forever
		begin
			tick();
			if (o_m_request)
			begin
				// Random 0 to 3 cycle stall before the address ack
				rng_state = xorshift32(rng_state);
				repeat (rng_state[1:0]) tick();
				i_sl_addr_ack = 1'b1;
				i_pa_valid    = 1'b1;
				tick();
				i_sl_addr_ack = 1'b0;
				i_pa_valid    = 1'b0;
				for (int b = 0; b < vram_pkg::BURST_LEN; b++)
				begin
					rng_state = xorshift32(rng_state);
					repeat (rng_state[1:0]) tick();
					// Write complete rides on the 16th dack
					i_m_wr_dack  = 1'b1;
					i_sl_wr_comp = (b == vram_pkg::BURST_LEN - 1);
					tick();
					i_m_wr_dack  = 1'b0;
					i_sl_wr_comp = 1'b0;
				end
			end
		end
	end

	//////////////////////////////
	// Checks
	//////////////////////////////

	// Writer idle until memory init
	assert property (@(posedge i_clk_100_bus) disable iff (i_sys_rst)
		!i_mem_init_done |-> (o_writer_state == vram_pkg::ST_INIT) && !o_m_request
		&& !o_m_wr_burst && !o_luma_valid && !o_new_line)
		else report_error("writer became active before memory init was done");

	// Pending request keeps its address
	assert property (@(posedge i_clk_100_bus) disable iff (i_sys_rst)
		o_m_request && !(i_sl_addr_ack && i_pa_valid) |=> o_m_request && $stable(o_m_abus))
		else report_error("request dropped or address moved before acknowledge");

	// Stalled beat holds its data and luma
	assert property (@(posedge i_clk_100_bus) disable iff (i_sys_rst)
		o_luma_valid && !i_m_wr_dack |=> (o_writer_state == vram_pkg::ST_WRITE)
		&& $stable(o_m_wr_data) && $stable(o_luma_data))
		else report_error("beat data changed while waiting for dack");

	// Outside the data phase only a request raises the burst strobe
	assert property (@(posedge i_clk_100_bus) disable iff (i_sys_rst)
		o_writer_state != vram_pkg::ST_WRITE |-> (o_m_wr_burst == o_m_request) && !o_luma_valid)
		else report_error("write burst or luma valid wrong outside the data phase");

	// Data phase strobes drop with write complete
	assert property (@(posedge i_clk_100_bus) disable iff (i_sys_rst)
		o_writer_state == vram_pkg::ST_WRITE |-> (o_m_wr_burst == !i_sl_wr_comp)
		&& (o_luma_valid == !i_sl_wr_comp))
		else report_error("write burst or luma valid wrong during the data phase");

	// Sampled mid-cycle, where inputs and outputs have settled
	always @(negedge i_clk_100_bus)
	begin
		if (!i_sys_rst && (o_m_request || o_writer_state == vram_pkg::ST_WRITE))
		begin
			if (line_idx >= NUM_LINES)
				report_error("bus activity after the last line");
			if (beat_cnt >= PIXELS)
				report_error("more than 64 beats in one line");
		end
		if (!i_sys_rst && o_m_request)
		begin
			exp_word = BASE + 32'(line_nums[line_idx]) * 32'd4096 + 32'(req_cnt) * 32'd64;
			assert (o_m_abus == exp_word) else report_value("o_m_abus", exp_word, o_m_abus);
			if (i_sl_addr_ack && i_pa_valid)
				req_cnt++;
		end
		if (!i_sys_rst && o_writer_state == vram_pkg::ST_WRITE)
		begin
			// Top byte zero, two low bits of each channel dropped
			exp_word = {8'h00, model_rgb[line_idx][vram_pkg::READ_OFFSET + beat_cnt] & 24'hfc_fc_fc};
			assert (o_m_wr_data == exp_word) else report_value("o_m_wr_data", exp_word, o_m_wr_data);
			exp_word = 32'(model_luma[line_idx][vram_pkg::READ_OFFSET + beat_cnt]);
			if (o_luma_valid)
			begin
				assert (o_luma_data == exp_word[7:0])
					else report_value("o_luma_data", exp_word, 32'(o_luma_data));
			end
			if (i_m_wr_dack)
				beat_cnt++;
		end
		// Line finished when the ready flag falls
		if (!i_sys_rst && prev_new_line && !o_new_line)
		begin
			assert (req_cnt == 4) else report_value("request count", 32'd4, 32'(req_cnt));
			assert (beat_cnt == PIXELS) else report_value("dack count", PIXELS, 32'(beat_cnt));
			assert (o_line_cnt == line_nums[line_idx])
				else report_value("o_line_cnt", 32'(line_nums[line_idx]), 32'(o_line_cnt));
			line_idx++;
			req_cnt  = 0;
			beat_cnt = 0;
		end
		prev_new_line = o_new_line;
	end

	always @(posedge i_clk_100_bus)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: only %0d of %0d lines written after %0d cycles",
				line_idx, NUM_LINES, cycle_cnt);
			$display("TEST RESULT: FAIL");
			$fatal(1, "simulation timeout");
		end
	end

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial
	begin
		rng_state       = 32'd3673;
		i_sys_rst       = 1'b1;
		i_pix_valid     = 1'b0;
		i_pix_rgb       = '0;
		i_pix_luma      = '0;
		i_line_end      = 1'b0;
		i_line_num      = '0;
		i_mem_init_done = 1'b0;
		i_sl_addr_ack   = 1'b0;
		i_pa_valid      = 1'b0;
		i_m_wr_dack     = 1'b0;
		i_sl_wr_comp    = 1'b0;
		repeat (10) @(posedge i_clk_100_bus);
		#1;
		i_sys_rst = 1'b0;
		// Idle window before memory init
		repeat (20) tick();
		i_mem_init_done = 1'b1;
		tick();
		for (int ln = 0; ln < NUM_LINES; ln++)
			send_line(ln);
		wait (line_idx == NUM_LINES);
		repeat (5) tick();
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// File: hdl/burst_writer.sv
// Bus master FSM that writes one buffered line to memory as a series of 16 beat bursts
`timescale 1ns/1ps

module burst_writer
#(
	parameter int          P_PIXELS_PER_LINE = 720,
	parameter logic [31:0] P_VIDEO_RAM_BASE  = 32'h0000_0000,
	parameter logic [31:0] P_BYTES_PER_LINE  = 32'd4096
)
(
	input  logic                              i_clk_100_bus,
	input  logic                              i_sys_rst,
	input  logic                              i_mem_init_done,
	input  logic                              i_line_ready,
	input  logic [vram_pkg::LINE_NUM_W-1:0]   i_line_num,
	input  logic [3*vram_pkg::PIX_W-1:0]      i_rd_rgb,
	input  logic [vram_pkg::PIX_W-1:0]        i_rd_luma,
	input  logic                              i_sl_addr_ack,
	input  logic                              i_pa_valid,
	input  logic                              i_m_wr_dack,
	input  logic                              i_sl_wr_comp,
	output logic [vram_pkg::BUF_ADDR_W-1:0]   o_rd_addr,
	output logic                              o_line_done,
	output logic                              o_m_request,
	output logic [vram_pkg::BUS_ADDR_W-1:0]   o_m_abus,
	output logic                              o_m_wr_burst,
	output logic [vram_pkg::BUS_DATA_W-1:0]   o_m_wr_data,
	output logic [vram_pkg::PIX_W-1:0]        o_luma_data,
	output logic                              o_luma_valid,
	output vram_pkg::writer_state_t           o_state
);

	localparam int BURSTS_PER_LINE = P_PIXELS_PER_LINE / vram_pkg::BURST_LEN;
	localparam int BURST_CNT_W     = $clog2(BURSTS_PER_LINE + 1);
	localparam int BEAT_CNT_W      = $clog2(vram_pkg::BURST_LEN);
	localparam int P               = vram_pkg::PIX_W;

	vram_pkg::writer_state_t r_state;
	vram_pkg::writer_state_t c_next;
	logic [BURST_CNT_W-1:0]  r_burst_cnt;
	logic [BURST_CNT_W-1:0]  c_burst_cnt;
	logic [BEAT_CNT_W-1:0]   r_beat_cnt;
	logic [BEAT_CNT_W-1:0]   c_beat_cnt;
	logic [vram_pkg::BUS_ADDR_W-1:0] r_m_abus;
	logic                    c_last_burst;
	logic [P-1:0]            c_red;
	logic [P-1:0]            c_green;
	logic [P-1:0]            c_blue;

	//////////////////////////////
	// Next state
	//////////////////////////////

	assign c_last_burst = (r_burst_cnt == BURST_CNT_W'(BURSTS_PER_LINE));

	always_comb
	begin
		c_next = r_state;
		case (r_state)
			// Hold off until the memory controller is up
			vram_pkg::ST_INIT:
				if (i_mem_init_done)
					c_next = vram_pkg::ST_START_LINE;
			vram_pkg::ST_START_LINE:
				if (i_line_ready)
					c_next = vram_pkg::ST_WRITE_REQUEST;
			// Request held with a stable address until accepted
			vram_pkg::ST_WRITE_REQUEST:
				if (i_sl_addr_ack && i_pa_valid)
					c_next = vram_pkg::ST_WRITE;
			vram_pkg::ST_WRITE:
				if (i_sl_wr_comp)
					c_next = vram_pkg::ST_WRITE_COMPLETE;
			vram_pkg::ST_WRITE_COMPLETE:
				c_next = c_last_burst ? vram_pkg::ST_START_LINE : vram_pkg::ST_WRITE_REQUEST;
			default:
				c_next = vram_pkg::ST_INIT;
		endcase
	end

	//////////////////////////////
	// Burst and beat counters
	//////////////////////////////

	always_comb
	begin
		c_burst_cnt = r_burst_cnt;
		c_beat_cnt  = r_beat_cnt;
		if (r_state == vram_pkg::ST_START_LINE)
		begin
			c_burst_cnt = '0;
			c_beat_cnt  = '0;
		end
		else if (r_state == vram_pkg::ST_WRITE)
		begin
			// Beat counter wraps to zero on the 16th dack
			if (i_m_wr_dack)
				c_beat_cnt = r_beat_cnt + 1'b1;
			if (i_sl_wr_comp)
				c_burst_cnt = r_burst_cnt + 1'b1;
		end
	end

	always_ff @(posedge i_clk_100_bus or posedge i_sys_rst)
	begin
		if (i_sys_rst)
		begin
			r_state     <= vram_pkg::ST_INIT;
			r_burst_cnt <= '0;
			r_beat_cnt  <= '0;
		end
		else
		begin
			r_state     <= c_next;
			r_burst_cnt <= c_burst_cnt;
			r_beat_cnt  <= c_beat_cnt;
		end
	end

	// Address of next cycle's beat, so buffer data lines up with it
	assign o_rd_addr = vram_pkg::BUF_ADDR_W'(vram_pkg::READ_OFFSET)
		+ vram_pkg::BUF_ADDR_W'({c_burst_cnt, c_beat_cnt});

	//////////////////////////////
	// Memory address
	//////////////////////////////

	always_ff @(posedge i_clk_100_bus)
	begin
		// Line base from the tag of the buffer being read
		if (r_state == vram_pkg::ST_START_LINE)
			r_m_abus <= P_VIDEO_RAM_BASE + P_BYTES_PER_LINE * i_line_num;
		else if (r_state == vram_pkg::ST_WRITE_COMPLETE)
			r_m_abus <= r_m_abus + vram_pkg::BUS_ADDR_W'(vram_pkg::BYTES_PER_BURST);
	end

	//////////////////////////////
	// Bus outputs
	//////////////////////////////

	assign c_red   = i_rd_rgb[3*P-1 -: P];
	assign c_green = i_rd_rgb[2*P-1 -: P];
	assign c_blue  = i_rd_rgb[P-1:0];

	// Zero top byte, then R G B with two low bits dropped
	assign o_m_wr_data = {{(vram_pkg::BUS_DATA_W-3*P){1'b0}},
		c_red[P-1:2], 2'b00, c_green[P-1:2], 2'b00, c_blue[P-1:2], 2'b00};

	assign o_m_abus     = r_m_abus;
	assign o_m_request  = (r_state == vram_pkg::ST_WRITE_REQUEST);
	// Burst drops with write complete
	assign o_m_wr_burst = o_m_request || ((r_state == vram_pkg::ST_WRITE) && !i_sl_wr_comp);
	assign o_luma_valid = (r_state == vram_pkg::ST_WRITE) && !i_sl_wr_comp;
	assign o_luma_data  = i_rd_luma;
	assign o_line_done  = (r_state == vram_pkg::ST_WRITE_COMPLETE) && c_last_burst;
	assign o_state      = r_state;

endmodule

// File: hdl/line_buffer_pair.sv
// Two line memories sharing one write and one registered read port, swapped by the buffer select
`timescale 1ns/1ps

module line_buffer_pair
(
	input  logic                              i_clk_100_bus,
	input  logic                              i_sys_rst,
	input  logic                              i_wr_en,
	input  logic                              i_wr_buf0,
	input  logic [vram_pkg::BUF_ADDR_W-1:0]   i_wr_addr,
	input  logic [3*vram_pkg::PIX_W-1:0]      i_wr_rgb,
	input  logic [vram_pkg::PIX_W-1:0]        i_wr_luma,
	input  logic [vram_pkg::BUF_ADDR_W-1:0]   i_rd_addr,
	output logic [3*vram_pkg::PIX_W-1:0]      o_rd_rgb,
	output logic [vram_pkg::PIX_W-1:0]        o_rd_luma
);

	localparam int WORD_W = 4 * vram_pkg::PIX_W;
	localparam int DEPTH  = 2 ** vram_pkg::BUF_ADDR_W;

	// Entry layout is luma over red, green, blue
	logic [WORD_W-1:0] mem [2][DEPTH];
	logic [WORD_W-1:0] r_rd_word;
	// Index 0 is buffer 0
	logic              c_wr_idx;
	logic              c_rd_idx;

	assign c_wr_idx = ~i_wr_buf0;
	// Reads always come from the buffer not being filled
	assign c_rd_idx = i_wr_buf0;

	//////////////////////////////
	// Write port
	//////////////////////////////

	always_ff @(posedge i_clk_100_bus)
	begin
		if (i_wr_en)
		begin
			mem[c_wr_idx][i_wr_addr] <= {i_wr_luma, i_wr_rgb};
		end
	end

	//////////////////////////////
	// Read port
	//////////////////////////////

	// One cycle from address to data
	always_ff @(posedge i_clk_100_bus or posedge i_sys_rst)
	begin
		if (i_sys_rst)
		begin
			r_rd_word <= '0;
		end
		else
		begin
			r_rd_word <= mem[c_rd_idx][i_rd_addr];
		end
	end

	assign o_rd_rgb  = r_rd_word[3*vram_pkg::PIX_W-1:0];
	assign o_rd_luma = r_rd_word[WORD_W-1 -: vram_pkg::PIX_W];

endmodule

// File: hdl/line_capture.sv
// Write side of the ping-pong line buffers; tracks fill address, buffer swap and line tags
`timescale 1ns/1ps

module line_capture
(
	input  logic                             i_clk_100_bus,
	input  logic                             i_sys_rst,
	input  logic                             i_pix_valid,
	input  logic                             i_line_end,
	input  logic [vram_pkg::LINE_NUM_W-1:0]  i_line_num,
	input  logic                             i_line_done,
	output logic [vram_pkg::BUF_ADDR_W-1:0]  o_wr_addr,
	output logic                             o_wr_buf0,
	output logic                             o_line_ready,
	output logic [vram_pkg::LINE_NUM_W-1:0]  o_rd_line_num
);

	logic [vram_pkg::BUF_ADDR_W-1:0] r_wr_addr;
	logic                            r_wr_buf0;
	logic                            r_line_ready;
	// Line number held by each buffer
	logic [vram_pkg::LINE_NUM_W-1:0] r_buf0_line_num;
	logic [vram_pkg::LINE_NUM_W-1:0] r_buf1_line_num;

	//////////////////////////////
	// Fill address and swap
	//////////////////////////////

	always_ff @(posedge i_clk_100_bus or posedge i_sys_rst)
	begin
		if (i_sys_rst)
		begin
			r_wr_addr <= '0;
			// Buffer 0 fills first
			r_wr_buf0 <= 1'b1;
		end
		else if (i_line_end)
		begin
			// Restart at entry 0 in the other buffer
			r_wr_addr <= '0;
			r_wr_buf0 <= ~r_wr_buf0;
		end
		else if (i_pix_valid)
		begin
			r_wr_addr <= r_wr_addr + 1'b1;
		end
	end

	//////////////////////////////
	// Line tags and ready flag
	//////////////////////////////

	always_ff @(posedge i_clk_100_bus or posedge i_sys_rst)
	begin
		if (i_sys_rst)
		begin
			r_buf0_line_num <= '0;
			r_buf1_line_num <= '0;
			r_line_ready    <= 1'b0;
		end
		else
		begin
			// Tag goes to the buffer that just filled
			if (i_line_end && r_wr_buf0)
				r_buf0_line_num <= i_line_num;
			if (i_line_end && !r_wr_buf0)
				r_buf1_line_num <= i_line_num;
			// Set wins; source must not end a line while one is pending
			if (i_line_end)
				r_line_ready <= 1'b1;
			else if (i_line_done)
				r_line_ready <= 1'b0;
		end
	end

	assign o_wr_addr     = r_wr_addr;
	assign o_wr_buf0     = r_wr_buf0;
	assign o_line_ready  = r_line_ready;
	// Read side is the buffer not being written
	assign o_rd_line_num = r_wr_buf0 ? r_buf1_line_num : r_buf0_line_num;

endmodule

// File: hdl/video_to_ram.sv
// Top level of the video-to-RAM bridge; captures lines into ping-pong buffers and bursts them out
`timescale 1ns/1ps

module video_to_ram
#(
	parameter int          P_PIXELS_PER_LINE = 720,
	parameter logic [31:0] P_VIDEO_RAM_BASE  = 32'h0000_0000,
	parameter logic [31:0] P_BYTES_PER_LINE  = 32'd4096
)
(
	input  logic                              i_clk_100_bus,
	input  logic                              i_sys_rst,

	// Pixel side
	input  logic                              i_pix_valid,
	input  logic [3*vram_pkg::PIX_W-1:0]      i_pix_rgb,
	input  logic [vram_pkg::PIX_W-1:0]        i_pix_luma,
	input  logic                              i_line_end,
	input  logic [vram_pkg::LINE_NUM_W-1:0]   i_line_num,
	input  logic                              i_mem_init_done,

	// Bus master
	output logic                              o_m_request,
	output logic                              o_m_wr_burst,
	output logic [vram_pkg::BUS_ADDR_W-1:0]   o_m_abus,
	output logic [vram_pkg::BUS_DATA_W-1:0]   o_m_wr_data,
	input  logic                              i_sl_addr_ack,
	input  logic                              i_pa_valid,
	input  logic                              i_m_wr_dack,
	input  logic                              i_sl_wr_comp,

	// Side outputs
	output logic [vram_pkg::PIX_W-1:0]        o_luma_data,
	output logic                              o_luma_valid,
	output logic                              o_new_line,
	output logic [vram_pkg::LINE_NUM_W-1:0]   o_line_cnt,
	output vram_pkg::writer_state_t           o_writer_state
);

	logic [vram_pkg::BUF_ADDR_W-1:0] s_wr_addr;
	logic                            s_wr_buf0;
	logic                            s_line_ready;
	logic [vram_pkg::LINE_NUM_W-1:0] s_rd_line_num;
	logic [vram_pkg::BUF_ADDR_W-1:0] s_rd_addr;
	logic                            s_line_done;
	logic [3*vram_pkg::PIX_W-1:0]    s_rd_rgb;
	logic [vram_pkg::PIX_W-1:0]      s_rd_luma;

	assign o_new_line = s_line_ready;
	assign o_line_cnt = s_rd_line_num;

	//////////////////////////////
	// Capture side
	//////////////////////////////

	line_capture u_line_capture
	(
		.i_clk_100_bus (i_clk_100_bus),
		.i_sys_rst     (i_sys_rst),
		.i_pix_valid   (i_pix_valid),
		.i_line_end    (i_line_end),
		.i_line_num    (i_line_num),
		.i_line_done   (s_line_done),
		.o_wr_addr     (s_wr_addr),
		.o_wr_buf0     (s_wr_buf0),
		.o_line_ready  (s_line_ready),
		.o_rd_line_num (s_rd_line_num)
	);

	line_buffer_pair u_line_buffer_pair
	(
		.i_clk_100_bus (i_clk_100_bus),
		.i_sys_rst     (i_sys_rst),
		.i_wr_en       (i_pix_valid),
		.i_wr_buf0     (s_wr_buf0),
		.i_wr_addr     (s_wr_addr),
		.i_wr_rgb      (i_pix_rgb),
		.i_wr_luma     (i_pix_luma),
		.i_rd_addr     (s_rd_addr),
		.o_rd_rgb      (s_rd_rgb),
		.o_rd_luma     (s_rd_luma)
	);

	//////////////////////////////
	// Bus side
	//////////////////////////////

	burst_writer
	#(
		.P_PIXELS_PER_LINE (P_PIXELS_PER_LINE),
		.P_VIDEO_RAM_BASE  (P_VIDEO_RAM_BASE),
		.P_BYTES_PER_LINE  (P_BYTES_PER_LINE)
	)
	u_burst_writer
	(
		.i_clk_100_bus   (i_clk_100_bus),
		.i_sys_rst       (i_sys_rst),
		.i_mem_init_done (i_mem_init_done),
		.i_line_ready    (s_line_ready),
		.i_line_num      (s_rd_line_num),
		.i_rd_rgb        (s_rd_rgb),
		.i_rd_luma       (s_rd_luma),
		.i_sl_addr_ack   (i_sl_addr_ack),
		.i_pa_valid      (i_pa_valid),
		.i_m_wr_dack     (i_m_wr_dack),
		.i_sl_wr_comp    (i_sl_wr_comp),
		.o_rd_addr       (s_rd_addr),
		.o_line_done     (s_line_done),
		.o_m_request     (o_m_request),
		.o_m_abus        (o_m_abus),
		.o_m_wr_burst    (o_m_wr_burst),
		.o_m_wr_data     (o_m_wr_data),
		.o_luma_data     (o_luma_data),
		.o_luma_valid    (o_luma_valid),
		.o_state         (o_writer_state)
	);

endmodule

// File: hdl/vram_pkg.sv
// Shared widths, burst constants and writer state type, referenced by scoped name from the RTL
package vram_pkg;

	//////////////////////////////
	// Data path widths
	//////////////////////////////

	// Bits per color channel and per luma sample
	localparam int PIX_W = 8;
	// Line number as tagged on each buffer
	localparam int LINE_NUM_W = 10;
	// 2048 entries per line buffer
	localparam int BUF_ADDR_W = 11;
	// Master address and write data bus
	localparam int BUS_ADDR_W = 32;
	localparam int BUS_DATA_W = 32;

	//////////////////////////////
	// Burst geometry
	//////////////////////////////

	// Every request is a 16 beat write burst
	localparam int BURST_LEN = 16;
	// One 32-bit word per beat
	localparam int BYTES_PER_BURST = BURST_LEN * 4;
	// First buffer entry sent, aligns the frame horizontally
	localparam int READ_OFFSET = 10;

	//////////////////////////////
	// Writer FSM
	//////////////////////////////

	typedef enum logic [2:0] {
		ST_INIT           = 3'd0,
		ST_START_LINE     = 3'd1,
		ST_WRITE_REQUEST  = 3'd2,
		ST_WRITE          = 3'd3,
		ST_WRITE_COMPLETE = 3'd4
	} writer_state_t;

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the video-to-RAM testbench with Verilator, then check the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal -f sim.f \
	--top-module tb_video_to_ram -o vsim \
	&& ./obj_dir/vsim > "$LOG" 2>&1 \
	|| echo "Build or simulation returned an error"

cat "$LOG" 2>/dev/null
grep -q "TEST RESULT: PASS" "$LOG" 2>/dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// File: sim.f
hdl/vram_pkg.sv
hdl/line_capture.sv
hdl/line_buffer_pair.sv
hdl/burst_writer.sv
hdl/video_to_ram.sv
dv/tb_video_to_ram.sv
